// File: Makefile
# Verilator build and run of the traffic generator testbench

VERILATOR ?= verilator
TOP       ?= tb_qbv_traffic_gen
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/credit_tx.sv
`timescale 1ns/1ns
`default_nettype none

module credit_tx (
    input  logic clk,
    input  logic reset,
    input  logic want,
    input  logic credit_return,
    output logic valid
);

    import qbv_pkg::*;

    // credits currently held by the sender
    credit_t credits;

    // a byte goes out only with a credit in hand
    assign valid = want && (credits != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credits <= credit_init;
        end else begin
            case ({valid, credit_return})
                // send only
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                // return only
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                // send and return cancel, or nothing happens
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/frame_builder.sv
`timescale 1ns/1ns
`default_nettype none

module frame_builder #(
    parameter qbv_pkg::pkt_hdr_t hdr = '0,
    parameter qbv_pkg::seq_id_t  seq_id = '0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             advance,
    input  qbv_pkg::pkt_id_t pkt_id,
    output qbv_pkg::byte_t   data,
    output logic             last
);

    import qbv_pkg::*;

    byte_idx_t byte_idx;
    // header, sequence id and packet id in wire order
    logic [$bits(pkt_hdr_t)+$bits(seq_id_t)+$bits(pkt_id_t)-1:0] prefix;
    logic      in_prefix;

    // byte position in the current frame
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_idx <= '0;
        end else if (start) begin
            byte_idx <= '0;
        end else if (advance) begin
            // wrap after the last byte
            if (last) begin
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    assign prefix = {hdr, seq_id, pkt_id};

    // bytes 0..21 come from the prefix, msb first
    assign in_prefix = byte_idx <
        byte_idx_t'(hdr_bytes + $bits(seq_id_t) / 8 + $bits(pkt_id_t) / 8);

    always_comb begin
        if (in_prefix) begin
            data = prefix[$bits(prefix) - 8 - 8 * byte_idx +: 8];
        end else begin
            // payload is the low byte of the index
            data = byte_idx[7:0];
        end
    end

    assign last = (byte_idx == byte_idx_t'(pkt_len_bytes - 1));

endmodule

`default_nettype wire

// File: hdl/gate_schedule.sv
`timescale 1ns/1ns
`default_nettype none

module gate_schedule (
    input  logic             clk,
    input  logic             reset,
    output qbv_pkg::ptp_ns_t ptp_ns,
    output logic             critical_tx,
    output logic             background_tx
);

    import qbv_pkg::*;

    gcl_time_t gcl_time;
    logic      in_critical_slot;
    // registered slot flag and its delayed copy
    logic      critical_slot;
    logic      critical_slot_d;
    logic      background_tick;

    // local ptp time, starts just before a period boundary
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ptp_ns <= ptp_ns_t'((1 << period_width) - ptp_reset_lead_ns);
        end else begin
            ptp_ns <= ptp_ns + ptp_ns_t'(ns_per_clk);
        end
    end

    // time within the period, in schedule units
    assign gcl_time = gcl_time_t'(ptp_ns[period_width-1:0] >> offset_width);

    // critical window [start, start + len)
    assign in_critical_slot =
        (gcl_time >= gcl_time_t'(critical_slot_start)) &&
        (gcl_time < gcl_time_t'(critical_slot_start + critical_slot_len));

    // background tick on every 2^14 ns boundary
    assign background_tick = (ptp_ns[background_interval_width-1:0] == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            critical_slot   <= 1'b0;
            critical_slot_d <= 1'b0;
        end else begin
            critical_slot   <= in_critical_slot;
            critical_slot_d <= critical_slot;
        end
    end

    // one pulse per window, on the rising edge of the flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            critical_tx <= 1'b0;
        end else begin
            critical_tx <= critical_slot && !critical_slot_d;
        end
    end

    // pulse lands one cycle after the boundary clock
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background_tx <= 1'b0;
        end else begin
            background_tx <= background_tick;
        end
    end

endmodule

`default_nettype wire

// File: hdl/qbv_pkg.sv
`default_nettype none

package qbv_pkg;

    // ptp nanosecond time and schedule time
    typedef logic [63:0] ptp_ns_t;
    // schedule time, in units of 2^offset_width ns
    typedef logic [16:0] gcl_time_t;

    // frame fields
    typedef logic [127:0] pkt_hdr_t;
    typedef logic [15:0] seq_id_t;
    typedef logic [31:0] pkt_id_t;
    typedef logic [7:0] byte_t;
    typedef logic [10:0] byte_idx_t;
    typedef logic [15:0] pkt_count_t;

    // transmit credits, enough for a buffer depth of up to 7
    typedef logic [2:0] credit_t;

    typedef enum logic [1:0] {
        src_idle,
        src_send,
        src_done
    } src_state_t;

    // time base, one 125 MHz clock per 8 ns
    localparam int ns_per_clk = 8;
    // counter starts this far ahead of a period boundary
    localparam int ptp_reset_lead_ns = 5000;

    // gate schedule, period 2^17 ns, unit 2^11 ns
    localparam int period_width = 17;
    localparam int offset_width = 11;
    localparam int critical_slot_start = 16;
    localparam int critical_slot_len = 25;
    localparam int background_interval_width = 14;

    // frame layout
    localparam int pkt_len_bytes = 64;
    localparam int hdr_bytes = 16;
    // vlan tag is already part of the critical header
    localparam pkt_hdr_t critical_hdr = 128'h00200081020000000000030000000000;
    localparam pkt_hdr_t background_hdr = 128'h0f0e0008010000000000030000000000;
    localparam seq_id_t critical_seq_id = 16'h6666;
    localparam seq_id_t background_seq_id = 16'hffff;
    localparam pkt_count_t critical_max_pkts = 16'd4;
    localparam pkt_count_t background_max_pkts = 16'hffff;

    // receiver buffer depth
    localparam credit_t credit_init = 3'd4;

endpackage

`default_nettype wire

// File: hdl/qbv_traffic_gen.sv
`timescale 1ns/1ns
`default_nettype none

module qbv_traffic_gen (
    input  logic             clk,
    input  logic             reset,
    input  logic             critical_credit_return,
    input  logic             background_credit_return,
    output qbv_pkg::ptp_ns_t ptp_ns,
    output qbv_pkg::byte_t   critical_data,
    output logic             critical_valid,
    output logic             critical_last,
    output logic             critical_done,
    output qbv_pkg::byte_t   background_data,
    output logic             background_valid,
    output logic             background_last,
    output logic             background_done
);

    import qbv_pkg::*;

    // trigger pulses from the schedule
    logic critical_tx;
    logic background_tx;

    gate_schedule i_gate_schedule (
        .clk           (clk),
        .reset         (reset),
        .ptp_ns        (ptp_ns),
        .critical_tx   (critical_tx),
        .background_tx (background_tx)
    );

    // scheduled flow, limited to a few frames
    traffic_source #(
        .hdr      (critical_hdr),
        .seq_id   (critical_seq_id),
        .max_pkts (critical_max_pkts)
    ) i_critical_source (
        .clk           (clk),
        .reset         (reset),
        .tx_trigger    (critical_tx),
        .credit_return (critical_credit_return),
        .data          (critical_data),
        .valid         (critical_valid),
        .last          (critical_last),
        .done          (critical_done)
    );

    // best effort flow on the periodic tick
    traffic_source #(
        .hdr      (background_hdr),
        .seq_id   (background_seq_id),
        .max_pkts (background_max_pkts)
    ) i_background_source (
        .clk           (clk),
        .reset         (reset),
        .tx_trigger    (background_tx),
        .credit_return (background_credit_return),
        .data          (background_data),
        .valid         (background_valid),
        .last          (background_last),
        .done          (background_done)
    );

endmodule

`default_nettype wire

// File: hdl/traffic_source.sv
`timescale 1ns/1ns
`default_nettype none

module traffic_source #(
    parameter qbv_pkg::pkt_hdr_t   hdr = qbv_pkg::background_hdr,
    parameter qbv_pkg::seq_id_t    seq_id = qbv_pkg::background_seq_id,
    parameter qbv_pkg::pkt_count_t max_pkts = qbv_pkg::background_max_pkts
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           tx_trigger,
    input  logic           credit_return,
    output qbv_pkg::byte_t data,
    output logic           valid,
    output logic           last,
    output logic           done
);

    import qbv_pkg::*;

    src_state_t state;
    pkt_count_t pkt_count;
    pkt_count_t pkt_count_next;
    logic       accept;
    logic       want;
    logic       frame_last;
    logic       frame_end;

    // triggers count only while idle
    assign accept = (state == src_idle) && tx_trigger;
    assign want = (state == src_send);

    // frame finishes on the byte that carries last
    assign frame_end = valid && frame_last;
    assign last = frame_end;
    assign pkt_count_next = pkt_count + 1'b1;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= src_idle;
            pkt_count <= '0;
        end else begin
            case (state)
                src_idle: begin
                    if (accept) begin
                        state <= src_send;
                    end
                end
                src_send: begin
                    if (frame_end) begin
                        pkt_count <= pkt_count_next;
                        // stop for good once the limit is hit
                        if (pkt_count_next == max_pkts) begin
                            state <= src_done;
                        end else begin
                            state <= src_idle;
                        end
                    end
                end
                default: begin
                    state <= src_done;
                end
            endcase
        end
    end

    assign done = (state == src_done);

    // byte index restarts on every accepted trigger
    frame_builder #(
        .hdr    (hdr),
        .seq_id (seq_id)
    ) i_frame_builder (
        .clk     (clk),
        .reset   (reset),
        .start   (accept),
        .advance (valid),
        .pkt_id  (pkt_id_t'(pkt_count)),
        .data    (data),
        .last    (frame_last)
    );

    // valid is want gated by the credit count
    credit_tx i_credit_tx (
        .clk           (clk),
        .reset         (reset),
        .want          (want),
        .credit_return (credit_return),
        .valid         (valid)
    );

endmodule

`default_nettype wire

// File: tests/qbv_traffic_gen_chk.sv
`timescale 1ns/1ns
`default_nettype none

module qbv_traffic_gen_chk (
    input logic clk,
    input logic reset,
    input logic critical_valid,
    input logic critical_last,
    input logic critical_credit_return,
    input logic background_valid,
    input logic background_last,
    input logic background_credit_return,
    input logic critical_tx,
    input logic background_tx
);

    import qbv_pkg::*;

    // model credit counts
    int critical_credits;
    int background_credits;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            critical_credits   <= int'(credit_init);
            background_credits <= int'(credit_init);
        end else begin
            critical_credits <= critical_credits - int'(critical_valid)
                + int'(critical_credit_return);
            background_credits <= background_credits - int'(background_valid)
                + int'(background_credit_return);
        end
    end

    a_critical_credit: assert property (@(posedge clk) disable iff (reset)
        critical_valid |-> critical_credits > 0) else $error("critical credit underflow");
    a_background_credit: assert property (@(posedge clk) disable iff (reset)
        background_valid |-> background_credits > 0) else $error("background credit underflow");
    a_critical_pulse: assert property (@(posedge clk) disable iff (reset)
        critical_tx |=> !critical_tx) else $error("critical_tx longer than one cycle");
    a_background_pulse: assert property (@(posedge clk) disable iff (reset)
        background_tx |=> !background_tx) else $error("background_tx longer than one cycle");
    a_critical_last: assert property (@(posedge clk) disable iff (reset)
        critical_last |-> critical_valid) else $error("critical last without valid");
    a_background_last: assert property (@(posedge clk) disable iff (reset)
        background_last |-> background_valid) else $error("background last without valid");

endmodule

bind qbv_traffic_gen qbv_traffic_gen_chk i_chk (
    .clk                      (clk),
    .reset                    (reset),
    .critical_valid           (critical_valid),
    .critical_last            (critical_last),
    .critical_credit_return   (critical_credit_return),
    .background_valid         (background_valid),
    .background_last          (background_last),
    .background_credit_return (background_credit_return),
    .critical_tx              (critical_tx),
    .background_tx            (background_tx)
);

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset held for two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tests/tb_qbv_traffic_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_qbv_traffic_gen;

    import qbv_pkg::*;

    // one schedule period in dut clocks, and the run limit
    localparam int period_cycles = (1 << period_width) / ns_per_clk;
    localparam int clk_period_ns = 4;
    localparam int timeout_ns = 6 * period_cycles * clk_period_ns + 20000;
    localparam int background_frames = 12;

    logic     clk;
    logic     reset;
    logic     critical_credit_return;
    logic     background_credit_return;
    ptp_ns_t  ptp_ns;
    byte_t    critical_data;
    byte_t    background_data;
    logic     critical_valid;
    logic     critical_last;
    logic     critical_done;
    logic     background_valid;
    logic     background_last;
    logic     background_done;

    // receiver bookkeeping, index 0 critical, 1 background
    int       taken [2];
    int       returned [2];
    logic     hold [2];
    logic [15:0] lfsr_state;
    pkt_id_t  next_background_id;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    qbv_traffic_gen i_dut (
        .clk                      (clk),
        .reset                    (reset),
        .critical_credit_return   (critical_credit_return),
        .background_credit_return (background_credit_return),
        .ptp_ns                   (ptp_ns),
        .critical_data            (critical_data),
        .critical_valid           (critical_valid),
        .critical_last            (critical_last),
        .critical_done            (critical_done),
        .background_data          (background_data),
        .background_valid         (background_valid),
        .background_last          (background_last),
        .background_done          (background_done)
    );

    initial begin
        critical_credit_return = 1'b0;
        background_credit_return = 1'b0;
        lfsr_state = 16'd37870;
        next_background_id = '0;
        for (int f = 0; f < 2; f++) begin
            taken[f] = 0;
            returned[f] = 0;
            hold[f] = 1'b0;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic take_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            fail_now($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_pkt_id(input string name, input pkt_id_t exp, input pkt_id_t act);
        if (exp !== act) begin
            fail_now($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_ptp(input string name, input ptp_ns_t exp, input ptp_ns_t act);
        if (exp !== act) begin
            fail_now($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_now($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // every valid, last and done output low
    task automatic verify_idle_outputs(input string phase);
        check_bit($sformatf("%s critical_valid", phase), 1'b0, critical_valid);
        check_bit($sformatf("%s critical_last", phase), 1'b0, critical_last);
        check_bit($sformatf("%s critical_done", phase), 1'b0, critical_done);
        check_bit($sformatf("%s background_valid", phase), 1'b0, background_valid);
        check_bit($sformatf("%s background_last", phase), 1'b0, background_last);
        check_bit($sformatf("%s background_done", phase), 1'b0, background_done);
    endtask

    // header and sequence id msb first, payload is the low index byte
    function automatic byte_t expected_byte(input pkt_hdr_t hdr, input seq_id_t seq,
                                            input int idx);
        if (idx < 16) begin
            return hdr[127 - 8 * idx -: 8];
        end else if (idx < 18) begin
            return seq[15 - 8 * (idx - 16) -: 8];
        end
        return byte_t'(idx);
    endfunction

    // receiver model, credits go back only for taken bytes
    always @(posedge clk) begin
        #1;
        if (reset) begin
            critical_credit_return = 1'b0;
            background_credit_return = 1'b0;
        end else begin
            critical_credit_return =
                (taken[0] > returned[0]) && !hold[0] && take_bit();
            background_credit_return =
                (taken[1] > returned[1]) && !hold[1] && take_bit();
        end
    end

    // credit ledger, sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (critical_valid) begin
                if (taken[0] - returned[0] >= int'(credit_init)) begin
                    fail_now("critical byte sent without a credit");
                end
                taken[0] = taken[0] + 1;
            end
            if (background_valid) begin
                if (taken[1] - returned[1] >= int'(credit_init)) begin
                    fail_now("background byte sent without a credit");
                end
                taken[1] = taken[1] + 1;
            end
            returned[0] = returned[0] + int'(critical_credit_return);
            returned[1] = returned[1] + int'(background_credit_return);
        end
    end

    // collect one frame of a flow and check every byte
    task automatic receive_frame(input int flow, input string name, input pkt_hdr_t hdr,
                                 input seq_id_t seq, input pkt_id_t exp_id,
                                 output ptp_ns_t first_ns);
        int      idx;
        logic    v;
        logic    l;
        byte_t   b;
        pkt_id_t got_id;
        idx = 0;
        got_id = '0;
        first_ns = '0;
        while (idx < pkt_len_bytes) begin
            @(negedge clk);
            v = (flow == 0) ? critical_valid : background_valid;
            l = (flow == 0) ? critical_last : background_last;
            b = (flow == 0) ? critical_data : background_data;
            if (v) begin
                if (idx == 0) begin
                    first_ns = ptp_ns;
                end
                // packet id bytes are gathered and compared as one word
                if (idx >= 18 && idx < 22) begin
                    got_id = {got_id[23:0], b};
                end else begin
                    check_byte($sformatf("%s byte %0d", name, idx),
                               expected_byte(hdr, seq, idx), b);
                end
                check_bit($sformatf("%s last at %0d", name, idx),
                          idx == pkt_len_bytes - 1, l);
                idx++;
            end else begin
                check_bit($sformatf("%s last without valid", name), 1'b0, l);
            end
        end
        check_pkt_id($sformatf("%s packet id", name), exp_id, got_id);
    endtask

    task automatic reset_test();
        ptp_ns_t start_ns;
        start_ns = ptp_ns_t'((1 << period_width) - ptp_reset_lead_ns);
        // first falling edge after the first rising edge, still in reset
        @(posedge clk);
        @(negedge clk);
        while (reset) begin
            check_ptp("ptp_ns in reset", start_ns, ptp_ns);
            verify_idle_outputs("in reset");
            @(negedge clk);
        end
        // stays quiet for a while after release, time steps by 8 ns per clock
        for (int c = 0; c < 8; c++) begin
            check_ptp("ptp_ns after reset", start_ns + ptp_ns_t'(ns_per_clk * c), ptp_ns);
            verify_idle_outputs("after reset");
            @(negedge clk);
        end
    endtask

    task automatic background_test();
        ptp_ns_t t;
        for (int k = 0; k < background_frames; k++) begin
            receive_frame(1, "background", background_hdr, background_seq_id,
                          next_background_id, t);
            next_background_id++;
        end
    endtask

    task automatic critical_test();
        ptp_ns_t t;
        int      unit;
        for (int k = 0; k < int'(critical_max_pkts); k++) begin
            check_bit("critical_done early", 1'b0, critical_done);
            receive_frame(0, "critical", critical_hdr, critical_seq_id, pkt_id_t'(k), t);
            unit = int'(t[period_width-1:0] >> offset_width);
            if (unit < critical_slot_start || unit >= critical_slot_start + critical_slot_len) begin
                fail_now($sformatf("critical frame %0d started outside its slot, unit %0d",
                                   k, unit));
            end
        end
        @(negedge clk);
        // at least one more window passes with the flow finished
        for (int c = 0; c < period_cycles + 4000; c++) begin
            check_bit("critical_done held", 1'b1, critical_done);
            check_bit("critical_valid after done", 1'b0, critical_valid);
            @(negedge clk);
        end
    endtask

    task automatic backpressure_test();
        ptp_ns_t t;
        hold[1] = 1'b1;
        fork
            receive_frame(1, "background held", background_hdr, background_seq_id,
                          next_background_id, t);
            begin
                // wait until every credit is out, then hold a while
                while (taken[1] - returned[1] < int'(credit_init)) begin
                    @(negedge clk);
                end
                repeat (300) begin
                    @(negedge clk);
                    check_bit("background_valid while stalled", 1'b0, background_valid);
                end
                hold[1] = 1'b0;
            end
        join
        next_background_id++;
    endtask

    initial begin
        reset_test();
        fork
            critical_test();
            begin
                background_test();
                backpressure_test();
            end
        join
        $display("Regression passed");
        $finish;
    end

    // watchdog, six schedule periods and some margin
    initial begin
        #(timeout_ns);
        fail_now("timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/qbv_pkg.sv
hdl/gate_schedule.sv
hdl/frame_builder.sv
hdl/credit_tx.sv
hdl/traffic_source.sv
hdl/qbv_traffic_gen.sv
tests/tb_clock.sv
tests/qbv_traffic_gen_chk.sv
tests/tb_qbv_traffic_gen.sv
